// ==== src.f ====
hw/pi_bus_pkg.sv
hw/pi_master.sv
hw/pi_bus_ctrl.sv
hw/pi_mem_slave.sv
hw/pi_bus_top.sv
dv/pi_bus_sva.sv
dv/pi_bus_tb.sv

// ==== Makefile ====
# Verilator build and run for the PI bus subsystem testbench

VERILATOR ?= verilator
TOP       ?= pi_bus_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a crash or a fail line in the log both count as failure
run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/pi_bus_tb.sv ====
//**********************************************************
// testbench for the PI bus subsystem
// applies a table of host commands to both masters, checks
// completions and read data against a reference memory
//**********************************************************
`timescale 1ns/1ps

module pi_bus_tb;
   import pi_bus_pkg::*;

   localparam int    MEM_DEPTH   = 64;
   localparam int    WAIT_CYCLES = 2;
   localparam int    TOUT_LIMIT  = 16;
   localparam int    NUM_TESTS   = 17;
   localparam int    CYCLE_LIMIT = NUM_TESTS * (TOUT_LIMIT + 20);
   localparam int    IDX_W       = $clog2(MEM_DEPTH);
   localparam addr_t STALL_BASE  = addr_t'(MEM_DEPTH);
   localparam addr_t ERR_BASE    = addr_t'(2 * MEM_DEPTH);

   typedef struct packed {
      logic [95:0] name;    // up to 12 characters
      logic [1:0]  msel;    // 2 means both masters
      logic        rd;
      logic        size;    // halfword
      logic        lock;
      addr_t       addr;
      addr_t       addr2;
      data_t       wdata;   // 0 takes the next lcg value
      logic        abort;   // expected outcome
   } test_row_t;

   logic  clk;
   logic  rst_n;
   logic  m0_cmd_rd, m0_cmd_wr, m0_cmd_lock, m0_cmd_size;
   addr_t m0_cmd_addr;
   data_t m0_cmd_wdata;
   logic  m0_st_last_data, m0_st_abort, m0_st_restart;
   data_t m0_host_rdata;
   logic  m1_cmd_rd, m1_cmd_wr, m1_cmd_lock, m1_cmd_size;
   addr_t m1_cmd_addr;
   data_t m1_cmd_wdata;
   logic  m1_st_last_data, m1_st_abort, m1_st_restart;
   data_t m1_host_rdata;

   test_row_t   tests [NUM_TESTS];
   data_t       ref_mem [MEM_DEPTH];
   logic [31:0] lcg_state;
   int          mismatch_cnt;
   int          fail_cnt;
   int          cycle_cnt = 0;

   pi_bus_top #(
      .MEM_DEPTH(MEM_DEPTH), .WAIT_CYCLES(WAIT_CYCLES), .TOUT_LIMIT(TOUT_LIMIT)
   ) u_dut (
      .clk(clk), .rst_n(rst_n),
      .m0_cmd_rd(m0_cmd_rd), .m0_cmd_wr(m0_cmd_wr), .m0_cmd_lock(m0_cmd_lock),
      .m0_cmd_size(m0_cmd_size), .m0_cmd_addr(m0_cmd_addr), .m0_cmd_wdata(m0_cmd_wdata),
      .m0_st_last_data(m0_st_last_data), .m0_st_abort(m0_st_abort),
      .m0_st_restart(m0_st_restart), .m0_host_rdata(m0_host_rdata),
      .m1_cmd_rd(m1_cmd_rd), .m1_cmd_wr(m1_cmd_wr), .m1_cmd_lock(m1_cmd_lock),
      .m1_cmd_size(m1_cmd_size), .m1_cmd_addr(m1_cmd_addr), .m1_cmd_wdata(m1_cmd_wdata),
      .m1_st_last_data(m1_st_last_data), .m1_st_abort(m1_st_abort),
      .m1_st_restart(m1_st_restart), .m1_host_rdata(m1_host_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      if (rst_n === 1'b1)
         cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT)
      begin
         $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
         $display("TB FAILED");
         $finish;
      end
   end

   function automatic data_t lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic data_t exp_read(input addr_t a, input logic half);
      data_t w;
      w = ref_mem[a[IDX_W-1:0]];
      return half ? {16'h0000, w[15:0]} : w;
   endfunction

   function automatic void apply_write(input addr_t a, input logic half, input data_t d);
      if (half)
         ref_mem[a[IDX_W-1:0]][15:0] = d[15:0];   // upper half untouched
      else
         ref_mem[a[IDX_W-1:0]] = d;
   endfunction

   task automatic drive_cmd(input int m, input logic rd, input logic wr, input logic lk,
                            input logic sz, input addr_t a, input data_t d);
      if (m == 0)
      begin
         m0_cmd_rd = rd;
         m0_cmd_wr = wr;
         m0_cmd_lock = lk;
         m0_cmd_size = sz;
         m0_cmd_addr = a;
         m0_cmd_wdata = d;
      end
      else
      begin
         m1_cmd_rd = rd;
         m1_cmd_wr = wr;
         m1_cmd_lock = lk;
         m1_cmd_size = sz;
         m1_cmd_addr = a;
         m1_cmd_wdata = d;
      end
   endtask

   task automatic drop_cmd(input int m);
      drive_cmd(m, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
   endtask

   task automatic compare_word(input string name, input string what,
                               input data_t exp, input data_t act);
      assert (exp === act)
      else
      begin
         mismatch_cnt++;
         $display("MISMATCH %s %s: expected %h, actual %h", name, what, exp, act);
      end
   endtask

   task automatic expect_true(input bit cond, input string msg);
      assert (cond)
      else
      begin
         fail_cnt++;
         $display("ERROR %s", msg);
      end
   endtask

   task automatic load_table();
      tests[0]  = '{"m0_word_wr", 2'd0, 1'b0, 1'b0, 1'b0, 30'h04, 30'h00, 32'h1234_5678, 1'b0};
      tests[1]  = '{"m0_word_rd", 2'd0, 1'b1, 1'b0, 1'b0, 30'h04, 30'h00, 32'h0, 1'b0};
      tests[2]  = '{"m1_word_wr", 2'd1, 1'b0, 1'b0, 1'b0, 30'h10, 30'h00, 32'h0, 1'b0};
      tests[3]  = '{"m1_word_rd", 2'd1, 1'b1, 1'b0, 1'b0, 30'h10, 30'h00, 32'h0, 1'b0};
      tests[4]  = '{"m0_half_base", 2'd0, 1'b0, 1'b0, 1'b0, 30'h08, 30'h00, 32'ha5a5_c3c3, 1'b0};
      tests[5]  = '{"m0_half_wr", 2'd0, 1'b0, 1'b1, 1'b0, 30'h08, 30'h00, 32'hffff_1e2f, 1'b0};
      tests[6]  = '{"m1_word_chk", 2'd1, 1'b1, 1'b0, 1'b0, 30'h08, 30'h00, 32'h0, 1'b0};
      tests[7]  = '{"m0_half_rd", 2'd0, 1'b1, 1'b1, 1'b0, 30'h08, 30'h00, 32'h0, 1'b0};
      tests[8]  = '{"m1_rtr_wr", 2'd1, 1'b0, 1'b0, 1'b0, 30'h06, 30'h00, 32'h0, 1'b0};
      tests[9]  = '{"m0_rtr_rd", 2'd0, 1'b1, 1'b0, 1'b0, 30'h06, 30'h00, 32'h0, 1'b0};
      tests[10] = '{"m0_err_wr", 2'd0, 1'b0, 1'b0, 1'b0, 30'h88, 30'h00, 32'hdead_beef, 1'b1};
      tests[11] = '{"m1_err_chk", 2'd1, 1'b1, 1'b0, 1'b0, 30'h08, 30'h00, 32'h0, 1'b0};
      tests[12] = '{"m0_stall_rd", 2'd0, 1'b1, 1'b0, 1'b0, 30'h50, 30'h00, 32'h0, 1'b1};
      tests[13] = '{"m1_prep_rd", 2'd1, 1'b1, 1'b0, 1'b0, 30'h10, 30'h00, 32'h0, 1'b0};
      tests[14] = '{"both_lock", 2'd2, 1'b1, 1'b0, 1'b1, 30'h20, 30'h24, 32'h0, 1'b0};
      tests[15] = '{"m0_lock_chk", 2'd0, 1'b1, 1'b0, 1'b0, 30'h20, 30'h00, 32'h0, 1'b0};
      tests[16] = '{"m1_lock_chk", 2'd1, 1'b1, 1'b0, 1'b0, 30'h24, 30'h00, 32'h0, 1'b0};
   endtask

   task automatic run_single(input test_row_t t);
      string name;
      int    m;
      int    waited;
      int    restarts;
      int    exp_rst;
      bit    done_seen;
      bit    abort_seen;
      data_t wd;
      begin
         name = string'(t.name);
         m = int'(t.msel);
         waited = 0;
         restarts = 0;
         done_seen = 1'b0;
         abort_seen = 1'b0;
         wd = (t.wdata == '0) ? lcg_next() : t.wdata;
         exp_rst = (t.addr < STALL_BASE && t.addr[1]) ? 1 : 0;   // bit-1 retract rule
         drive_cmd(m, t.rd, !t.rd, t.lock, t.size, t.addr, wd);
         while (!done_seen && !abort_seen)
         begin
            @(negedge clk);
            waited++;
            if (m == 0 ? m0_st_restart : m1_st_restart)
               restarts++;
            done_seen = (m == 0) ? m0_st_last_data : m1_st_last_data;
            abort_seen = (m == 0) ? m0_st_abort : m1_st_abort;
         end
         drop_cmd(m);
         compare_word(name, "outcome", data_t'(t.abort), data_t'(abort_seen));
         compare_word(name, "restarts", data_t'(exp_rst), data_t'(restarts));
         if (done_seen && t.rd)
            compare_word(name, "rdata", exp_read(t.addr, t.size),
                         (m == 0) ? m0_host_rdata : m1_host_rdata);
         if (done_seen && !t.rd)
            apply_write(t.addr, t.size, wd);
         if (t.addr >= STALL_BASE && t.addr < ERR_BASE)
            expect_true(waited <= TOUT_LIMIT + 8,
                        $sformatf("%s: stalled access took %0d cycles to abort", name, waited));
      end
   endtask

   // master 0 writes a locked pair, master 1 reads the second address
   task automatic run_both(input test_row_t t);
      string name;
      data_t wd0;
      data_t wd1;
      bit    second_sent;
      bit    m0_fin;
      bit    m1_fin;
      bit    m1_early;
      bit    saw_abort;
      bit    saw_restart;
      begin
         name = string'(t.name);
         wd0 = (t.wdata == '0) ? lcg_next() : t.wdata;
         wd1 = lcg_next();
         second_sent = 1'b0;
         m0_fin = 1'b0;
         m1_fin = 1'b0;
         m1_early = 1'b0;
         saw_abort = 1'b0;
         saw_restart = 1'b0;
         drive_cmd(0, 1'b0, 1'b1, t.lock, 1'b0, t.addr, wd0);
         drive_cmd(1, 1'b1, 1'b0, 1'b0, t.size, t.addr2, '0);
         while (!(m0_fin && m1_fin) && !saw_abort)
         begin
            @(negedge clk);
            if (m0_st_abort || m1_st_abort)
               saw_abort = 1'b1;
            if (m0_st_restart || m1_st_restart)
               saw_restart = 1'b1;
            if (m0_st_last_data && !second_sent)
            begin
               apply_write(t.addr, 1'b0, wd0);
               drive_cmd(0, 1'b0, 1'b1, 1'b0, 1'b0, t.addr2, wd1);   // last of the pair
               second_sent = 1'b1;
            end
            else if (m0_st_last_data)
            begin
               apply_write(t.addr2, 1'b0, wd1);
               drop_cmd(0);
               m0_fin = 1'b1;
            end
            if (m1_st_last_data)
            begin
               m1_early = !m0_fin;
               compare_word(name, "m1 rdata", exp_read(t.addr2, t.size), m1_host_rdata);
               drop_cmd(1);
               m1_fin = 1'b1;
            end
         end
         drop_cmd(0);
         drop_cmd(1);
         expect_true(!saw_abort, $sformatf("%s: a transfer was aborted", name));
         expect_true(!saw_restart, $sformatf("%s: unexpected restart", name));
         expect_true(!m1_early, $sformatf("%s: master 1 finished inside the locked pair", name));
      end
   endtask

   initial
   begin
      rst_n = 1'b0;
      drop_cmd(0);
      drop_cmd(1);
      lcg_state = 32'heaa1f7a2;
      mismatch_cnt = 0;
      fail_cnt = 0;
      load_table();
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      repeat (2) @(negedge clk);
      for (int i = 0; i < NUM_TESTS; i++)
      begin
         if (tests[i].msel == 2'd2)
            run_both(tests[i]);
         else
            run_single(tests[i]);
         repeat (2) @(negedge clk);
      end
      $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatch_cnt, fail_cnt, u_dut.u_bus_ctrl.u_sva.err_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0 && u_dut.u_bus_ctrl.u_sva.err_cnt == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== dv/pi_bus_sva.sv ====
//**********************************************************
// assertions on the PI bus controller
// bound into pi_bus_ctrl, checks grants against requests
// and the shape of the timeout pulse
//**********************************************************
`timescale 1ns/1ps

module pi_bus_sva #(
   parameter int TOUT_LIMIT = 16
) (
   input logic             clk,
   input logic             rst_n,
   input logic             req0,
   input logic             req1,
   input logic             gnt0,
   input logic             gnt1,
   input logic             tout,
   input pi_bus_pkg::ack_t ack
);
   import pi_bus_pkg::*;

   int err_cnt = 0;   // failed assertions so far

   one_gnt: assert property (@(posedge clk) disable iff (!rst_n) !(gnt0 && gnt1))
      else
      begin
         err_cnt++;
         $error("both masters granted in the same cycle");
      end

   gnt0_req: assert property (@(posedge clk) disable iff (!rst_n) gnt0 |-> req0)
      else
      begin
         err_cnt++;
         $error("grant to master 0 without a request");
      end

   gnt1_req: assert property (@(posedge clk) disable iff (!rst_n) gnt1 |-> req1)
      else
      begin
         err_cnt++;
         $error("grant to master 1 without a request");
      end

   // watchdog fires on the last of TOUT_LIMIT wait cycles
   tout_wat: assert property (@(posedge clk) disable iff (!rst_n)
                              $rose(tout) |-> ack == ACK_WAT &&
                                             $past(ack, TOUT_LIMIT - 1) == ACK_WAT)
      else
      begin
         err_cnt++;
         $error("timeout raised outside a full run of wait codes");
      end

   tout_pulse: assert property (@(posedge clk) disable iff (!rst_n) tout |=> !tout)
      else
      begin
         err_cnt++;
         $error("timeout held for more than one cycle");
      end

endmodule

bind pi_bus_ctrl pi_bus_sva #(.TOUT_LIMIT(TOUT_LIMIT)) u_sva (
   .clk(clk), .rst_n(rst_n),
   .req0(req0), .req1(req1),
   .gnt0(gnt0), .gnt1(gnt1),
   .tout(tout), .ack(ack)
);

// ==== hw/pi_bus_top.sv ====
//**********************************************************
// PI bus subsystem top
// two master controllers, the bus controller and one memory
// slave; masters drive zero when idle so bus lines are ORed
//**********************************************************
`timescale 1ns/1ps

module pi_bus_top #(
   parameter int MEM_DEPTH   = 64,
   parameter int WAIT_CYCLES = 2,
   parameter int TOUT_LIMIT  = 16
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              m0_cmd_rd,
   input  logic              m0_cmd_wr,
   input  logic              m0_cmd_lock,
   input  logic              m0_cmd_size,
   input  pi_bus_pkg::addr_t m0_cmd_addr,
   input  pi_bus_pkg::data_t m0_cmd_wdata,
   output logic              m0_st_last_data,
   output logic              m0_st_abort,
   output logic              m0_st_restart,
   output pi_bus_pkg::data_t m0_host_rdata,
   input  logic              m1_cmd_rd,
   input  logic              m1_cmd_wr,
   input  logic              m1_cmd_lock,
   input  logic              m1_cmd_size,
   input  pi_bus_pkg::addr_t m1_cmd_addr,
   input  pi_bus_pkg::data_t m1_cmd_wdata,
   output logic              m1_st_last_data,
   output logic              m1_st_abort,
   output logic              m1_st_restart,
   output pi_bus_pkg::data_t m1_host_rdata
);
   import pi_bus_pkg::*;

   logic  req0;
   logic  req1;
   logic  gnt0;
   logic  gnt1;
   logic  tout;
   logic  m0_read;
   logic  m1_read;
   logic  m0_lock;
   logic  m1_lock;
   addr_t m0_addr;
   addr_t m1_addr;
   opc_t  m0_opc;
   opc_t  m1_opc;
   data_t m0_wdata;
   data_t m1_wdata;
   logic  bus_read;
   logic  bus_lock;
   addr_t bus_addr;
   opc_t  bus_opc;
   data_t bus_wdata;
   data_t bus_rdata;
   ack_t  bus_ack;

   assign bus_read  = m0_read | m1_read;
   assign bus_lock  = m0_lock | m1_lock;
   assign bus_addr  = m0_addr | m1_addr;
   assign bus_opc   = m0_opc | m1_opc;
   assign bus_wdata = m0_wdata | m1_wdata;

   pi_master u_master0 (
      .clk(clk), .rst_n(rst_n),
      .cmd_rd(m0_cmd_rd), .cmd_wr(m0_cmd_wr), .cmd_lock(m0_cmd_lock),
      .cmd_size(m0_cmd_size), .cmd_addr(m0_cmd_addr), .cmd_wdata(m0_cmd_wdata),
      .gnt(gnt0), .tout(tout), .ack(bus_ack), .rdata(bus_rdata),
      .req(req0), .read(m0_read), .lock(m0_lock), .addr(m0_addr),
      .opc(m0_opc), .wdata(m0_wdata),
      .st_last_data(m0_st_last_data), .st_abort(m0_st_abort),
      .st_restart(m0_st_restart), .host_rdata(m0_host_rdata)
   );

   pi_master u_master1 (
      .clk(clk), .rst_n(rst_n),
      .cmd_rd(m1_cmd_rd), .cmd_wr(m1_cmd_wr), .cmd_lock(m1_cmd_lock),
      .cmd_size(m1_cmd_size), .cmd_addr(m1_cmd_addr), .cmd_wdata(m1_cmd_wdata),
      .gnt(gnt1), .tout(tout), .ack(bus_ack), .rdata(bus_rdata),
      .req(req1), .read(m1_read), .lock(m1_lock), .addr(m1_addr),
      .opc(m1_opc), .wdata(m1_wdata),
      .st_last_data(m1_st_last_data), .st_abort(m1_st_abort),
      .st_restart(m1_st_restart), .host_rdata(m1_host_rdata)
   );

   pi_bus_ctrl #(.TOUT_LIMIT(TOUT_LIMIT)) u_bus_ctrl (
      .clk(clk), .rst_n(rst_n),
      .req0(req0), .req1(req1), .lock(bus_lock), .ack(bus_ack),
      .gnt0(gnt0), .gnt1(gnt1), .tout(tout)
   );

   pi_mem_slave #(.MEM_DEPTH(MEM_DEPTH), .WAIT_CYCLES(WAIT_CYCLES)) u_slave (
      .clk(clk), .rst_n(rst_n),
      .addr(bus_addr), .opc(bus_opc), .read(bus_read), .wdata(bus_wdata),
      .ack(bus_ack), .rdata(bus_rdata)
   );

endmodule

// ==== hw/pi_mem_slave.sv ====
//**********************************************************
// PI bus memory slave
// memory below MEM_DEPTH with WAIT_CYCLES wait states,
// a stall window up to twice that, error decode above
// bit-1 addresses are retracted once before being served
//**********************************************************
`timescale 1ns/1ps

module pi_mem_slave #(
   parameter int MEM_DEPTH   = 64,
   parameter int WAIT_CYCLES = 2
) (
   input  logic              clk,
   input  logic              rst_n,
   input  pi_bus_pkg::addr_t addr,
   input  pi_bus_pkg::opc_t  opc,
   input  logic              read,
   input  pi_bus_pkg::data_t wdata,
   output pi_bus_pkg::ack_t  ack,
   output pi_bus_pkg::data_t rdata
);
   import pi_bus_pkg::*;

   localparam int    IDX_W      = $clog2(MEM_DEPTH);
   localparam int    WCNT_W     = $clog2(WAIT_CYCLES + 2);
   localparam addr_t STALL_BASE = addr_t'(MEM_DEPTH);
   localparam addr_t ERR_BASE   = addr_t'(2 * MEM_DEPTH);

   typedef enum logic [1:0] {SL_IDLE, SL_WAIT, SL_STALL, SL_RESP} slv_state_t;

   slv_state_t        state;
   logic [WCNT_W-1:0] wcnt;
   logic              rtr_valid;
   addr_t             rtr_addr;
   logic [IDX_W-1:0]  cur_idx;
   logic              cur_half;
   logic              cur_read;
   data_t             mem [MEM_DEPTH];
   logic              addr_phase;
   logic              mem_hit;
   logic              retract;
   logic [IDX_W-1:0]  rd_idx;
   logic              rd_half;
   logic              rd_read;
   data_t             rd_val;

   assign addr_phase = (state == SL_IDLE) && (opc != '0);
   assign mem_hit    = addr < STALL_BASE;
   assign retract    = addr_phase && mem_hit && addr[1] &&
                       !(rtr_valid && rtr_addr == addr);

   // fresh address in idle, latched one while waiting
   assign rd_idx  = (state == SL_IDLE) ? addr[IDX_W-1:0] : cur_idx;
   assign rd_half = (state == SL_IDLE) ? (opc == OPC_HALF) : cur_half;
   assign rd_read = (state == SL_IDLE) ? read : cur_read;
   assign rd_val  = rd_half ? {16'h0000, mem[rd_idx][15:0]} : mem[rd_idx];

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state     <= SL_IDLE;
         ack       <= ACK_IDLE;
         rdata     <= '0;
         wcnt      <= '0;
         rtr_valid <= 1'b0;
      end
      else
      begin
         ack   <= ACK_IDLE;
         rdata <= '0;
         case (state)
            SL_IDLE:
            begin
               if (addr_phase)
               begin
                  if (addr >= ERR_BASE)
                  begin
                     ack   <= ACK_ERR;
                     state <= SL_RESP;
                  end
                  else if (!mem_hit)
                  begin
                     ack   <= ACK_WAT;
                     state <= SL_STALL;
                  end
                  else if (retract)
                  begin
                     ack       <= ACK_RTR;
                     rtr_valid <= 1'b1;
                     state     <= SL_RESP;
                  end
                  else
                  begin
                     if (addr[1])
                        rtr_valid <= 1'b0;   // retried access, serve it
                     if (WAIT_CYCLES == 0)
                     begin
                        ack   <= ACK_RDY;
                        rdata <= rd_read ? rd_val : '0;
                        state <= SL_RESP;
                     end
                     else
                     begin
                        ack   <= ACK_WAT;
                        wcnt  <= WCNT_W'(1);
                        state <= SL_WAIT;
                     end
                  end
               end
            end
            SL_WAIT:
            begin
               if (wcnt == WCNT_W'(WAIT_CYCLES))
               begin
                  ack   <= ACK_RDY;
                  rdata <= rd_read ? rd_val : '0;
                  state <= SL_RESP;
               end
               else
               begin
                  ack  <= ACK_WAT;
                  wcnt <= wcnt + 1'b1;
               end
            end
            SL_STALL:
            begin
               if (opc != '0)
                  ack <= ACK_WAT;   // until the master gives up
               else
                  state <= SL_IDLE;
            end
            default: state <= SL_IDLE;   // final code shown for one cycle
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (addr_phase)
      begin
         cur_idx  <= addr[IDX_W-1:0];
         cur_half <= (opc == OPC_HALF);
         cur_read <= read;
      end
      if (retract)
         rtr_addr <= addr;
      if (state == SL_RESP && ack == ACK_RDY && !cur_read)
      begin
         if (cur_half)
            mem[cur_idx] <= {mem[cur_idx][31:16], wdata[15:0]};
         else
            mem[cur_idx] <= wdata;
      end
   end

endmodule

// ==== hw/pi_bus_ctrl.sv ====
//**********************************************************
// PI bus controller
// round-robin grant between two masters, ownership kept
// over locked transfers, and the data-phase timeout watchdog
//**********************************************************
`timescale 1ns/1ps

module pi_bus_ctrl #(
   parameter int TOUT_LIMIT = 16
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             req0,
   input  logic             req1,
   input  logic             lock,
   input  pi_bus_pkg::ack_t ack,
   output logic             gnt0,
   output logic             gnt1,
   output logic             tout
);
   import pi_bus_pkg::*;

   localparam int TCNT_W = $clog2(TOUT_LIMIT + 1);

   typedef enum logic [1:0] {C_FREE, C_BUSY, C_HOLD} ctrl_state_t;

   ctrl_state_t       state;
   logic              last1;   // master 1 had the last grant
   logic [TCNT_W-1:0] wat_cnt;
   logic              pick1;
   logic              release_bus;

   assign pick1 = req1 && (!req0 || !last1);
   assign gnt0  = (state == C_FREE) && req0 && !pick1;
   assign gnt1  = (state == C_FREE) && pick1;

   assign tout = (ack == ACK_WAT) && (wat_cnt == TCNT_W'(TOUT_LIMIT - 1));

   assign release_bus = tout || ack == ACK_ERR || ack == ACK_RTR ||
                        (ack == ACK_RDY && !lock) ||
                        (state == C_HOLD && ack == ACK_IDLE && !lock);   // owner went idle

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state   <= C_FREE;
         last1   <= 1'b1;   // master 0 goes first
         wat_cnt <= '0;
      end
      else
      begin
         if (ack == ACK_WAT && !tout)
            wat_cnt <= wat_cnt + 1'b1;
         else
            wat_cnt <= '0;
         case (state)
            C_FREE:
            begin
               if (gnt0 || gnt1)
               begin
                  last1 <= gnt1;
                  state <= C_BUSY;
               end
            end
            default:
            begin
               if (release_bus)
                  state <= C_FREE;
               else if (ack == ACK_RDY)
                  state <= C_HOLD;   // locked, keep the owner
               else if (ack != ACK_IDLE)
                  state <= C_BUSY;
            end
         endcase
      end
   end

endmodule

// ==== hw/pi_master.sv ====
//**********************************************************
// PI bus master controller
// takes held rd/wr command levels from a local host and
// runs request, address and data phases on the bus
// completion, abort and restart are pulsed back to the host
//**********************************************************
`timescale 1ns/1ps

module pi_master (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cmd_rd,
   input  logic              cmd_wr,
   input  logic              cmd_lock,
   input  logic              cmd_size,
   input  pi_bus_pkg::addr_t cmd_addr,
   input  pi_bus_pkg::data_t cmd_wdata,
   input  logic              gnt,
   input  logic              tout,
   input  pi_bus_pkg::ack_t  ack,
   input  pi_bus_pkg::data_t rdata,
   output logic              req,
   output logic              read,
   output logic              lock,
   output pi_bus_pkg::addr_t addr,
   output pi_bus_pkg::opc_t  opc,
   output pi_bus_pkg::data_t wdata,
   output logic              st_last_data,
   output logic              st_abort,
   output logic              st_restart,
   output pi_bus_pkg::data_t host_rdata
);
   import pi_bus_pkg::*;

   typedef enum logic [2:0] {S_IDLE, S_REQ, S_ADDR, S_DATA, S_RTRCT} mst_state_t;

   mst_state_t state;
   logic       lock_wait;   // locked transfer done, waiting on the host
   logic       cmd_any;

   assign cmd_any = cmd_rd | cmd_wr;

   function automatic opc_t size_opc(input logic half);
      return half ? OPC_HALF : OPC_WORD;
   endfunction

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state        <= S_IDLE;
         lock_wait    <= 1'b0;
         req          <= 1'b0;
         read         <= 1'b0;
         lock         <= 1'b0;
         addr         <= '0;
         opc          <= '0;
         wdata        <= '0;
         st_last_data <= 1'b0;
         st_abort     <= 1'b0;
         st_restart   <= 1'b0;
      end
      else
      begin
         st_last_data <= 1'b0;
         st_abort     <= 1'b0;
         st_restart   <= 1'b0;
         case (state)
            S_IDLE:
            begin
               if (cmd_any)
               begin
                  req   <= 1'b1;
                  state <= S_REQ;
               end
            end
            S_REQ, S_RTRCT:
            begin
               if (gnt)
               begin
                  req        <= 1'b0;
                  addr       <= cmd_addr;
                  opc        <= size_opc(cmd_size);
                  read       <= cmd_rd;
                  lock       <= cmd_lock;
                  st_restart <= (state == S_RTRCT);
                  state      <= S_ADDR;
               end
            end
            S_ADDR:
            begin
               lock  <= cmd_lock;
               wdata <= read ? '0 : cmd_wdata;   // write data for the data phase
               state <= S_DATA;
            end
            S_DATA:
            begin
               if (lock_wait)
               begin
                  lock_wait <= 1'b0;
                  if (cmd_any)
                  begin
                     // bus still owned, skip the request
                     addr  <= cmd_addr;
                     opc   <= size_opc(cmd_size);
                     read  <= cmd_rd;
                     state <= S_ADDR;
                  end
                  else
                  begin
                     lock  <= 1'b0;   // lets the controller free the bus
                     state <= S_IDLE;
                  end
               end
               else if (tout || ack == ACK_ERR)
               begin
                  addr     <= '0;
                  opc      <= '0;
                  read     <= 1'b0;
                  lock     <= 1'b0;
                  wdata    <= '0;
                  st_abort <= 1'b1;
                  state    <= S_IDLE;
               end
               else if (ack == ACK_RTR)
               begin
                  addr  <= '0;
                  opc   <= '0;
                  read  <= 1'b0;
                  lock  <= 1'b0;
                  wdata <= '0;
                  req   <= 1'b1;   // same command again
                  state <= S_RTRCT;
               end
               else if (ack == ACK_RDY)
               begin
                  addr         <= '0;
                  opc          <= '0;
                  read         <= 1'b0;
                  wdata        <= '0;
                  st_last_data <= 1'b1;
                  if (lock)
                     lock_wait <= 1'b1;   // lock stays up one more cycle
                  else
                     state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == S_DATA && !lock_wait && ack == ACK_RDY && read)
         host_rdata <= rdata;
   end

endmodule

// ==== hw/pi_bus_pkg.sv ====
//**********************************************************
// shared types and codes of the PI bus subsystem
// widths, transfer opcodes and slave acknowledge codes
// used by every RTL module and by the testbench
//**********************************************************

package pi_bus_pkg;

   typedef logic [29:0] addr_t;   // word address
   typedef logic [31:0] data_t;
   typedef logic [3:0]  opc_t;
   typedef logic [2:0]  ack_t;

   // zero opc means no address phase on the bus
   localparam opc_t OPC_WORD = 4'b0010;
   localparam opc_t OPC_HALF = 4'b0001;   // low 16 bits only

   // acknowledge codes driven by the slave in the data phase
   localparam ack_t ACK_IDLE = 3'd0;
   localparam ack_t ACK_ERR  = 3'd1;
   localparam ack_t ACK_WAT  = 3'd3;
   localparam ack_t ACK_RDY  = 3'd4;
   localparam ack_t ACK_RTR  = 3'd5;

endpackage
